// ==== src/ttc_defs.svh ====
// TTC lite shared widths, channel count and APB address field positions
`ifndef TTC_DEFS_SVH
`define TTC_DEFS_SVH

// ------------------------------
// Channel and datapath widths
// ------------------------------
`define TTC_NUM_CH       3        // Timer channels
`define TTC_CNT_W        16       // Counter, interval and match width
`define TTC_DATA_W       32       // APB data bus
`define TTC_ADDR_W       8        // APB address bus

// ------------------------------
// APB address fields
// ------------------------------
// Channel index sits just above the word offset
`define TTC_CH_LSB       2
`define TTC_CH_MSB       3
// Register index in the upper nibble
`define TTC_REG_LSB      4
`define TTC_REG_MSB      7

// ------------------------------
// Control and status widths
// ------------------------------
`define TTC_CLK_CTRL_W   5        // Prescale enable plus 4-bit select
`define TTC_CNTR_CTRL_W  5        // Disable, interval, down, match, restart
`define TTC_IRQ_W        5        // Interval, three matches, overflow

`endif

// ==== src/ttc_pkg.sv ====
// TTC lite types for counter values, register map and control bit positions
`include "ttc_defs.svh"

package ttc_pkg;

   // Counter, interval and match values share one width
   typedef logic [`TTC_CNT_W-1:0] ttc_cnt_t;

   // Register index within a channel, from paddr[7:4]
   typedef enum logic [3:0] {
      REG_CLK_CTRL   = 4'd0,   // RW
      REG_CNTR_CTRL  = 4'd1,   // RW, restart bit self-clears
      REG_COUNT      = 4'd2,   // RO
      REG_INTERVAL   = 4'd3,   // RW
      REG_MATCH1     = 4'd4,   // RW
      REG_MATCH2     = 4'd5,   // RW
      REG_MATCH3     = 4'd6,   // RW
      REG_IRQ_STATUS = 4'd7,   // RO, clear on read
      REG_IRQ_EN     = 4'd8    // RW
   } ttc_reg_e;               // 9 to 15 unmapped

   // Bit positions in status and enable
   typedef enum logic [2:0] {
      IRQ_INTERVAL = 3'd0,
      IRQ_MATCH1   = 3'd1,
      IRQ_MATCH2   = 3'd2,
      IRQ_MATCH3   = 3'd3,
      IRQ_OVERFLOW = 3'd4
   } ttc_irq_bit_e;

   // Bit positions in counter control
   typedef enum logic [2:0] {
      CNTR_DISABLE  = 3'd0,    // Stops tick and prescaler
      CNTR_INTERVAL = 3'd1,    // Reload mode, else free running
      CNTR_DOWN     = 3'd2,
      CNTR_MATCH_EN = 3'd3,
      CNTR_RESTART  = 3'd4     // Loads start value, then clears
   } ttc_cntr_bit_e;

endpackage

// ==== src/ttc_apb_decode.sv ====
// TTC lite APB decoder, turns transfers into channel strobes and read requests
`include "ttc_defs.svh"

module ttc_apb_decode (
   input  logic                          pclk,
   input  logic                          rst_n,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [`TTC_ADDR_W-1:0]        paddr,
   input  logic [`TTC_DATA_W-1:0]        pwdata,
   output logic [`TTC_NUM_CH-1:0]        wr_en,      // One per channel
   output ttc_pkg::ttc_reg_e             wr_reg,
   output ttc_pkg::ttc_cnt_t             wr_data,
   output logic [`TTC_NUM_CH-1:0]        clear_irq,  // Status read, access phase
   output logic                          rd_en,      // Read setup phase
   output logic [1:0]                    rd_ch,
   output ttc_pkg::ttc_reg_e             rd_reg
);

   localparam int CH_W  = `TTC_CH_MSB - `TTC_CH_LSB + 1;
   localparam int REG_W = `TTC_REG_MSB - `TTC_REG_LSB + 1;

   logic [CH_W-1:0]  ch_idx;
   logic [REG_W-1:0] reg_idx;
   logic             ch_ok;      // Channel exists
   logic             reg_ok;     // Register mapped
   logic             reg_wr_ok;  // Mapped and writable
   logic             setup_ph;
   logic             access_ph;

   // ------------------------------
   // Address split and map check
   // ------------------------------
   assign ch_idx    = paddr[`TTC_CH_MSB:`TTC_CH_LSB];
   assign reg_idx   = paddr[`TTC_REG_MSB:`TTC_REG_LSB];
   assign ch_ok     = (int'(ch_idx) < `TTC_NUM_CH);    // Index 3 has no channel
   assign reg_ok    = (reg_idx <= REG_W'(ttc_pkg::REG_IRQ_EN));
   assign reg_wr_ok = reg_ok &&
                      (reg_idx != REG_W'(ttc_pkg::REG_COUNT)) &&
                      (reg_idx != REG_W'(ttc_pkg::REG_IRQ_STATUS));

   assign setup_ph  = psel && !penable;
   assign access_ph = psel && penable;

   // ------------------------------
   // Per-channel strobes
   // ------------------------------
   always_comb begin
      for (int i = 0; i < `TTC_NUM_CH; i++) begin
         // Write lands on the edge closing the access phase
         wr_en[i]     = access_ph && pwrite && ch_ok && reg_wr_ok &&
                        (ch_idx == CH_W'(i));
         clear_irq[i] = access_ph && !pwrite && ch_ok &&
                        (reg_idx == REG_W'(ttc_pkg::REG_IRQ_STATUS)) &&
                        (ch_idx == CH_W'(i));
      end
   end

   assign wr_reg  = ttc_pkg::ttc_reg_e'(reg_idx);
   assign wr_data = pwdata[`TTC_CNT_W-1:0];    // Upper half ignored

   // Readback samples at end of setup, data held through access
   assign rd_en  = setup_ph && !pwrite && ch_ok && reg_ok;
   assign rd_ch  = ch_idx;
   assign rd_reg = ttc_pkg::ttc_reg_e'(reg_idx);

   // Bus master must never raise penable outside a selected transfer
   a_penable_needs_psel: assert property (
      @(posedge pclk) disable iff (!rst_n)
      penable |-> psel
   );

endmodule

// ==== src/ttc_prescaler.sv ====
// TTC lite prescaler, divides pclk by a power of two into a count tick
`include "ttc_defs.svh"

module ttc_prescaler (
   input  logic                          pclk,
   input  logic                          rst_n,
   input  logic                          enable,    // Channel running
   input  logic                          restart,   // Clock control written
   input  logic [`TTC_CLK_CTRL_W-1:0]    clk_ctrl,
   output logic                          tick
);

   logic [15:0] div_cnt;
   logic [15:0] div_max;   // Period minus one
   logic [3:0]  sel;       // Prescale select N
   logic        pre_en;    // Prescale enable

   assign pre_en = clk_ctrl[0];
   assign sel    = clk_ctrl[4:1];

   // 2^(N+1) - 1, N=15 gives full 16 bits
   assign div_max = 16'hffff >> (4'd15 - sel);

   // ------------------------------
   // Divider count
   // ------------------------------
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         div_cnt <= '0;
      end else if (restart || !enable || !pre_en) begin
         div_cnt <= '0;                            // Hold at phase zero
      end else if (div_cnt == div_max) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 16'd1;
      end
   end

   // Every cycle when bypassed, else once per period
   assign tick = enable && (!pre_en || (div_cnt == div_max));

endmodule

// ==== src/ttc_timer_channel.sv ====
// TTC lite timer channel with registers, up/down counter, match and interrupt logic
`include "ttc_defs.svh"

module ttc_timer_channel (
   input  logic                          pclk,
   input  logic                          rst_n,
   input  logic                          wr_en,
   input  ttc_pkg::ttc_reg_e             wr_reg,
   input  ttc_pkg::ttc_cnt_t             wr_data,
   input  logic                          clear_irq,   // Status read access
   output logic [`TTC_CLK_CTRL_W-1:0]    clk_ctrl,
   output logic [`TTC_CNTR_CTRL_W-1:0]   cntr_ctrl,
   output ttc_pkg::ttc_cnt_t             count,
   output ttc_pkg::ttc_cnt_t             interval,
   output ttc_pkg::ttc_cnt_t             match1,
   output ttc_pkg::ttc_cnt_t             match2,
   output ttc_pkg::ttc_cnt_t             match3,
   output logic [`TTC_IRQ_W-1:0]         irq_status,
   output logic [`TTC_IRQ_W-1:0]         irq_en,
   output logic                          irq
);

   ttc_pkg::ttc_cnt_t       cnt_nxt;     // Count after this tick
   ttc_pkg::ttc_cnt_t       start_val;   // Loaded by restart
   logic [`TTC_IRQ_W-1:0]   evt;         // Events if tick taken
   logic                    tick;
   logic                    enable;
   logic                    pre_restart;
   logic                    restart;
   logic                    down;
   logic                    intv_mode;

   assign enable      = !cntr_ctrl[ttc_pkg::CNTR_DISABLE];
   assign down        = cntr_ctrl[ttc_pkg::CNTR_DOWN];
   assign intv_mode   = cntr_ctrl[ttc_pkg::CNTR_INTERVAL];
   assign restart     = cntr_ctrl[ttc_pkg::CNTR_RESTART];
   assign pre_restart = wr_en && (wr_reg == ttc_pkg::REG_CLK_CTRL);

   ttc_prescaler u_prescaler (
      .pclk     (pclk),
      .rst_n    (rst_n),
      .enable   (enable),
      .restart  (pre_restart),
      .clk_ctrl (clk_ctrl),
      .tick     (tick)
   );

   // ------------------------------
   // Register file
   // ------------------------------
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         clk_ctrl <= '0;
         interval <= '0;
         match1   <= '0;
         match2   <= '0;
         match3   <= '0;
         irq_en   <= '0;
      end else if (wr_en) begin
         case (wr_reg)
            ttc_pkg::REG_CLK_CTRL: clk_ctrl <= wr_data[`TTC_CLK_CTRL_W-1:0];
            ttc_pkg::REG_INTERVAL: interval <= wr_data;
            ttc_pkg::REG_MATCH1:   match1   <= wr_data;
            ttc_pkg::REG_MATCH2:   match2   <= wr_data;
            ttc_pkg::REG_MATCH3:   match3   <= wr_data;
            ttc_pkg::REG_IRQ_EN:   irq_en   <= wr_data[`TTC_IRQ_W-1:0];
            default: ;                                  // Handled below or read only
         endcase
      end
   end

   // Counter control, restart bit drops after one cycle
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         cntr_ctrl <= '0;
      end else if (wr_en && (wr_reg == ttc_pkg::REG_CNTR_CTRL)) begin
         cntr_ctrl <= wr_data[`TTC_CNTR_CTRL_W-1:0];
      end else if (restart) begin
         cntr_ctrl[ttc_pkg::CNTR_RESTART] <= 1'b0;
      end
   end

   // ------------------------------
   // Next count and events
   // ------------------------------
   assign start_val = !down    ? '0 :
                      intv_mode ? interval : '1;

   always_comb begin
      cnt_nxt = count;
      evt     = '0;
      if (intv_mode && down) begin
         if (count == '0) begin
            cnt_nxt                    = interval;   // Reload at bottom
            evt[ttc_pkg::IRQ_INTERVAL] = 1'b1;
         end else begin
            cnt_nxt = count - 1'b1;
         end
      end else if (intv_mode) begin
         // Catches an interval lowered below the count too
         if (count >= interval) begin
            cnt_nxt                    = '0;
            evt[ttc_pkg::IRQ_INTERVAL] = 1'b1;
         end else begin
            cnt_nxt = count + 1'b1;
         end
      end else begin
         cnt_nxt                    = down ? count - 1'b1 : count + 1'b1;
         evt[ttc_pkg::IRQ_OVERFLOW] = down ? (count == '0) : (count == '1);
      end
      if (cntr_ctrl[ttc_pkg::CNTR_MATCH_EN]) begin
         evt[ttc_pkg::IRQ_MATCH1] = (cnt_nxt == match1);
         evt[ttc_pkg::IRQ_MATCH2] = (cnt_nxt == match2);
         evt[ttc_pkg::IRQ_MATCH3] = (cnt_nxt == match3);
      end
   end

   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         count <= '0;
      end else if (restart) begin
         count <= start_val;        // Wins over a tick
      end else if (tick) begin
         count <= cnt_nxt;
      end
   end

   // ------------------------------
   // Interrupt status
   // ------------------------------
   // Event on the clearing edge survives
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         irq_status <= '0;
      end else begin
         irq_status <= (clear_irq ? '0 : irq_status) |
                       ((tick && !restart) ? evt : '0);
      end
   end

   assign irq = |(irq_status & irq_en);

   // Reload keeps an up-counting interval count in range, barring a write
   a_up_count_in_range: assert property (
      @(posedge pclk) disable iff (!rst_n)
      (tick && !wr_en && intv_mode && !down && (interval != '0))
         |=> (count <= interval)
   );

endmodule

// ==== src/ttc_readback.sv ====
// TTC lite readback mux, registers the addressed channel register onto prdata
`include "ttc_defs.svh"

module ttc_readback (
   input  logic                          pclk,
   input  logic                          rst_n,
   input  logic                          rd_en,
   input  logic [1:0]                    rd_ch,
   input  ttc_pkg::ttc_reg_e             rd_reg,
   input  logic [`TTC_CLK_CTRL_W-1:0]    clk_ctrl   [`TTC_NUM_CH],
   input  logic [`TTC_CNTR_CTRL_W-1:0]   cntr_ctrl  [`TTC_NUM_CH],
   input  ttc_pkg::ttc_cnt_t             count      [`TTC_NUM_CH],
   input  ttc_pkg::ttc_cnt_t             interval   [`TTC_NUM_CH],
   input  ttc_pkg::ttc_cnt_t             match1     [`TTC_NUM_CH],
   input  ttc_pkg::ttc_cnt_t             match2     [`TTC_NUM_CH],
   input  ttc_pkg::ttc_cnt_t             match3     [`TTC_NUM_CH],
   input  logic [`TTC_IRQ_W-1:0]         irq_status [`TTC_NUM_CH],
   input  logic [`TTC_IRQ_W-1:0]         irq_en     [`TTC_NUM_CH],
   output logic [`TTC_DATA_W-1:0]        prdata
);

   localparam int DW = `TTC_DATA_W;

   logic [DW-1:0] rd_val;   // Zero-extended field

   // ------------------------------
   // Field select
   // ------------------------------
   // rd_ch is only trusted when rd_en is high
   always_comb begin
      rd_val = '0;
      case (rd_reg)
         ttc_pkg::REG_CLK_CTRL:   rd_val = DW'(clk_ctrl[rd_ch]);
         ttc_pkg::REG_CNTR_CTRL:  rd_val = DW'(cntr_ctrl[rd_ch]);
         ttc_pkg::REG_COUNT:      rd_val = DW'(count[rd_ch]);
         ttc_pkg::REG_INTERVAL:   rd_val = DW'(interval[rd_ch]);
         ttc_pkg::REG_MATCH1:     rd_val = DW'(match1[rd_ch]);
         ttc_pkg::REG_MATCH2:     rd_val = DW'(match2[rd_ch]);
         ttc_pkg::REG_MATCH3:     rd_val = DW'(match3[rd_ch]);
         ttc_pkg::REG_IRQ_STATUS: rd_val = DW'(irq_status[rd_ch]);
         ttc_pkg::REG_IRQ_EN:     rd_val = DW'(irq_en[rd_ch]);
         default:                 rd_val = '0;     // Unmapped
      endcase
   end

   // ------------------------------
   // Read data register
   // ------------------------------
   // Captured at end of setup, stable for the access phase
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         prdata <= '0;
      end else if (rd_en) begin
         prdata <= rd_val;
      end else begin
         prdata <= '0;           // Bus idles at zero
      end
   end

endmodule

// ==== src/ttc_lite.sv ====
// TTC lite top, APB slave with three timer channels and one interrupt per channel
`include "ttc_defs.svh"

module ttc_lite (
   input  logic                          pclk,
   input  logic                          rst_n,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [`TTC_ADDR_W-1:0]        paddr,
   input  logic [`TTC_DATA_W-1:0]        pwdata,
   output logic [`TTC_DATA_W-1:0]        prdata,
   output logic [`TTC_NUM_CH-1:0]        interrupt   // One per channel
);

   // ------------------------------
   // Decoder to channels and readback
   // ------------------------------
   logic [`TTC_NUM_CH-1:0]      wr_en;
   ttc_pkg::ttc_reg_e           wr_reg;
   ttc_pkg::ttc_cnt_t           wr_data;
   logic [`TTC_NUM_CH-1:0]      clear_irq;
   logic                        rd_en;
   logic [1:0]                  rd_ch;
   ttc_pkg::ttc_reg_e           rd_reg;

   // Channel register views
   logic [`TTC_CLK_CTRL_W-1:0]  clk_ctrl   [`TTC_NUM_CH];
   logic [`TTC_CNTR_CTRL_W-1:0] cntr_ctrl  [`TTC_NUM_CH];
   ttc_pkg::ttc_cnt_t           count      [`TTC_NUM_CH];
   ttc_pkg::ttc_cnt_t           interval   [`TTC_NUM_CH];
   ttc_pkg::ttc_cnt_t           match1     [`TTC_NUM_CH];
   ttc_pkg::ttc_cnt_t           match2     [`TTC_NUM_CH];
   ttc_pkg::ttc_cnt_t           match3     [`TTC_NUM_CH];
   logic [`TTC_IRQ_W-1:0]       irq_status [`TTC_NUM_CH];
   logic [`TTC_IRQ_W-1:0]       irq_en     [`TTC_NUM_CH];

   ttc_apb_decode u_decode (
      .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
      .wr_en, .wr_reg, .wr_data, .clear_irq, .rd_en, .rd_ch, .rd_reg
   );

   // Identical channels, shared write bus
   for (genvar ch = 0; ch < `TTC_NUM_CH; ch++) begin : g_ch
      ttc_timer_channel u_channel (
         .pclk       (pclk),
         .rst_n      (rst_n),
         .wr_en      (wr_en[ch]),
         .wr_reg     (wr_reg),
         .wr_data    (wr_data),
         .clear_irq  (clear_irq[ch]),
         .clk_ctrl   (clk_ctrl[ch]),
         .cntr_ctrl  (cntr_ctrl[ch]),
         .count      (count[ch]),
         .interval   (interval[ch]),
         .match1     (match1[ch]),
         .match2     (match2[ch]),
         .match3     (match3[ch]),
         .irq_status (irq_status[ch]),
         .irq_en     (irq_en[ch]),
         .irq        (interrupt[ch])
      );
   end

   ttc_readback u_readback (
      .pclk, .rst_n, .rd_en, .rd_ch, .rd_reg,
      .clk_ctrl, .cntr_ctrl, .count, .interval,
      .match1, .match2, .match3, .irq_status, .irq_en,
      .prdata
   );

endmodule

// ==== testbench/tb_ttc_tasks.svh ====
// TTC lite testbench APB bus tasks and directed timer tests

// ------------------------------
// APB bus access
// ------------------------------
// Entered just after a falling edge, leaves the bus idle on one
task automatic write_reg(input int ch, input int idx, input logic [31:0] data);
   psel    = 1'b1;                  // Setup
   penable = 1'b0;
   pwrite  = 1'b1;
   paddr   = 8'((idx << 4) | (ch << 2));
   pwdata  = data;
   @(negedge pclk);
   penable = 1'b1;                  // Access phase lands on next rising edge
   @(negedge pclk);
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic read_reg(input int ch, input int idx, output logic [31:0] data);
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = 1'b0;
   paddr   = 8'((idx << 4) | (ch << 2));
   @(negedge pclk);
   penable = 1'b1;
   data    = prdata;                // Captured at end of setup
   @(negedge pclk);
   psel    = 1'b0;
   penable = 1'b0;
endtask

task automatic compare_val(input logic [31:0] exp, input logic [31:0] act);
   if (act !== exp) begin
      err_cnt++;
      $display("error %s expected %0h actual %0h", test_name, exp, act);
   end
endtask

task automatic expect_reg(input int ch, input int idx, input logic [31:0] exp);
   logic [31:0] act;
   read_reg(ch, idx, act);
   compare_val(exp, act);
endtask

// Poll one interrupt pin on falling edges
task automatic wait_irq(input int ch, input int limit);
   int n;
   n = 0;
   while (!interrupt[ch] && n < limit) begin
      @(negedge pclk);
      n++;
   end
   if (!interrupt[ch]) begin
      timeout_cnt++;
      $display("timeout waiting for interrupt %0d in %s", ch, test_name);
   end
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic reset_and_access();
   logic [31:0] shadow [3][9];
   logic [31:0] data;
   logic [31:0] mask;
   test_name = "reset_access";
   compare_val(32'h0, 32'(interrupt));
   for (int ch = 0; ch < 3; ch++) begin
      for (int r = 0; r < 9; r++) begin
         if (r != 2) begin            // Counters already run from reset
            expect_reg(ch, r, 32'h0);
         end
      end
   end
   for (int ch = 0; ch < 3; ch++) begin
      write_reg(ch, 1, 32'h1);        // Stop the channel first
      for (int r = 0; r < 9; r++) begin
         data = $random(seed);
         if (r == 1) begin
            data = (data | 32'h1) & ~32'h10;   // Stay stopped without restart
         end
         mask          = (r == 0 || r == 1 || r == 8) ? 32'h1f : 32'hffff;
         shadow[ch][r] = 32'h0;
         if (r != 2 && r != 7) begin
            write_reg(ch, r, data);
            shadow[ch][r] = data & mask;
         end
      end
   end
   write_reg(3, 3, 32'hbeef);         // No channel 3
   write_reg(0, 9, 32'hbeef);         // Unmapped register
   for (int ch = 0; ch < 3; ch++) begin
      for (int r = 0; r < 9; r++) begin
         if (r != 2) begin
            expect_reg(ch, r, shadow[ch][r]);
         end
      end
   end
   for (int ch = 0; ch < 4; ch++) begin
      for (int r = 9; r < 16; r++) begin
         expect_reg(ch, r, 32'h0);
      end
   end
   for (int r = 0; r < 9; r++) begin
      expect_reg(3, r, 32'h0);
   end
endtask

task automatic interval_up_match();
   logic [31:0] prev;
   logic [31:0] cur;
   logic        wrapped;
   test_name = "interval_up";
   wrapped   = 1'b0;
   write_reg(0, 1, 32'h01);           // Stopped while configuring
   write_reg(0, 0, 32'h00);           // No prescale
   write_reg(0, 3, 32'd20);
   write_reg(0, 4, 32'd7);
   write_reg(0, 5, 32'hffff);         // Out of reach
   write_reg(0, 6, 32'hffff);
   write_reg(0, 8, 32'h03);           // Interval and match1
   read_reg(0, 7, cur);
   write_reg(0, 1, 32'h1a);           // Interval, match enable, restart
   wait_irq(0, 100);                  // Match1 at 7 comes first
   read_reg(0, 2, prev);
   for (int n = 0; n < 50 && !wrapped; n++) begin
      read_reg(0, 2, cur);
      if (cur > 32'd20 || prev > 32'd20) begin
         err_cnt++;
         $display("error %s expected at most 20 actual %0d", test_name, cur);
      end
      wrapped = (cur < prev);         // Reload to zero seen
      prev    = cur;
   end
   if (!wrapped) begin
      timeout_cnt++;
      $display("timeout waiting for interval reload in %s", test_name);
   end
   expect_reg(0, 7, 32'h03);
endtask

task automatic clear_and_mask();
   logic [31:0] val;
   test_name = "clear_on_read";
   write_reg(0, 1, 32'h01);
   read_reg(0, 7, val);               // First read clears
   expect_reg(0, 7, 32'h0);
   compare_val(32'h0, 32'(interrupt));
   write_reg(0, 8, 32'h00);           // All masked
   write_reg(0, 1, 32'h1a);
   val = 32'h0;
   for (int n = 0; n < 50 && val == 32'h0; n++) begin
      if (interrupt[0] !== 1'b0) begin
         err_cnt++;
         $display("error %s expected 0 actual %0b", test_name, interrupt[0]);
      end
      read_reg(0, 7, val);
   end
   if (val == 32'h0) begin
      timeout_cnt++;
      $display("timeout waiting for masked status in %s", test_name);
   end else begin
      compare_val(32'h02, val);       // Match1 at 7 before interval at 20
   end
   write_reg(0, 1, 32'h01);
endtask

task automatic overflow_down();
   logic [31:0] val;
   test_name = "overflow";
   write_reg(1, 1, 32'h01);
   write_reg(1, 0, 32'h00);
   write_reg(1, 8, 32'h10);           // Overflow only
   write_reg(1, 1, 32'h15);           // Restart down while still stopped
   @(negedge pclk);                   // Start value loads one edge later
   expect_reg(1, 2, 32'hffff);
   read_reg(1, 7, val);
   write_reg(1, 1, 32'h04);           // Free-running down
   wait_irq(1, 70000);
   expect_reg(1, 7, 32'h10);
   write_reg(1, 1, 32'h01);
endtask

task automatic prescaler_rate();
   logic [31:0] val;
   test_name = "prescaler";
   write_reg(2, 1, 32'h01);
   write_reg(2, 0, 32'h05);           // Enable with N = 2 for a tick every 8
   write_reg(2, 1, 32'h11);           // Restart up while still stopped
   write_reg(2, 1, 32'h00);
   repeat (800) @(negedge pclk);
   read_reg(2, 2, val);
   if (val < 32'd98 || val > 32'd102) begin
      err_cnt++;
      $display("error %s expected 100+-2 actual %0d", test_name, val);
   end
   write_reg(2, 1, 32'h01);
endtask

task automatic channel_independence();
   logic [31:0] val;
   logic [31:0] intv;
   test_name = "independence";
   for (int ch = 0; ch < 3; ch++) begin
      write_reg(ch, 1, 32'h01);
      write_reg(ch, 0, 32'h00);
      write_reg(ch, 8, 32'h01);       // Interval only
      read_reg(ch, 7, val);
   end
   for (int ch = 0; ch < 3; ch++) begin
      intv = 32'd10 + ({$random(seed)} % 32'd51);
      write_reg(ch, 3, intv);
      write_reg(ch, 1, (ch == 1) ? 32'h16 : 32'h12);   // Channel 1 counts down
      wait_irq(ch, 200);
      compare_val(32'(3'b001 << ch), 32'(interrupt));
      write_reg(ch, 1, 32'h01);
      for (int k = 0; k < 3; k++) begin
         expect_reg(k, 7, (k == ch) ? 32'h01 : 32'h00);
      end
   end
endtask

// ==== testbench/tb_ttc_lite.sv ====
// TTC lite testbench top, drives the APB slave through directed timer tests
`include "ttc_defs.svh"

module tb_ttc_lite;

   logic                     pclk;
   logic                     rst_n;
   logic                     psel;
   logic                     penable;
   logic                     pwrite;
   logic [`TTC_ADDR_W-1:0]   paddr;
   logic [`TTC_DATA_W-1:0]   pwdata;
   logic [`TTC_DATA_W-1:0]   prdata;
   logic [`TTC_NUM_CH-1:0]   interrupt;

   integer seed;            // $random state
   int     err_cnt;         // Wrong values
   int     timeout_cnt;     // Polls that ran out
   string  test_name;       // Shown in error lines

   ttc_lite u_dut (
      .pclk      (pclk),
      .rst_n     (rst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   // ------------------------------
   // Clock, 10 time units
   // ------------------------------
   initial begin
      pclk = 1'b0;
      forever #5 pclk = ~pclk;
   end

   `include "tb_ttc_tasks.svh"

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      seed        = 32'h754c;
      err_cnt     = 0;
      timeout_cnt = 0;
      test_name   = "reset";
      rst_n       = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      repeat (10) @(negedge pclk);   // Ten reset edges
      rst_n = 1'b1;
      @(negedge pclk);

      reset_and_access();
      interval_up_match();
      clear_and_mask();
      overflow_down();
      prescaler_rate();
      channel_independence();

      $display("errors %0d, timeouts %0d", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+src
+incdir+testbench
src/ttc_pkg.sv
src/ttc_apb_decode.sv
src/ttc_prescaler.sv
src/ttc_timer_channel.sv
src/ttc_readback.sv
src/ttc_lite.sv
testbench/tb_ttc_lite.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the TTC lite testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ttc_lite \
   -f list.f -o sim_ttc_lite \
   && ./obj_dir/sim_ttc_lite > sim.log 2>&1 \
   || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TEST PASSED" sim.log && exit 0 || exit 1
